//--- arcade_input_properties.sv
// Control-input assertions
// Handshake and flag rules for the event FIFO and the cabinet mapper,
// bound into the top level where both blocks meet.

`timescale 1ns/10ps

module arcade_input_properties (
	input logic                     clk_sys,
	input logic                     rst_n,
	input logic [10:0]              ps2_key,
	input logic                     push,
	input logic                     empty,
	input logic                     overflow,
	input input_pkg::mapper_state_e state
);
	import input_pkg::*;

	// Head shows one cycle after a push into an empty FIFO
	fall_through: assert property (@(posedge clk_sys) disable iff (!rst_n)
		push && empty |=> !empty)
		else $error("pushed event did not reach the FIFO head");

	// Back-to-back pushes need two toggle flips
	push_per_toggle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		push && $past(push) |-> $past(ps2_key[10]) != $past(ps2_key[10], 2))
		else $error("push held for a single toggle");

	overflow_sticky: assert property (@(posedge clk_sys)
		$past(overflow) && !overflow |-> !$past(rst_n))
		else $error("overflow cleared without reset");

	// One enable cycle in every four
	enable_period: assert property (@(posedge clk_sys) disable iff (!rst_n)
		state == mst_apply |=> state == mst_idle ##1 state == mst_idle
			##1 state == mst_idle ##1 state == mst_apply)
		else $error("mapper enable not one cycle in four");

endmodule

//--- arcade_input_top.sv
// Arcade control-input top level
// Keyboard capture feeds the event FIFO, the cabinet mapper drains it
// at the game clock-enable rate and drives the CPU input registers.

`timescale 1ns/10ps
`include "input_defs.svh"

module arcade_input_top (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic [10:0] ps2_key,
	input  logic [7:0]  joystick_0,
	input  logic [7:0]  joystick_1,
	input  logic        rotate,
	output logic [7:0]  in0_reg,
	output logic [7:0]  in1_reg,
	output logic [7:0]  dipsw_reg,
	output logic        overflow
);
	import input_pkg::*;

	logic    push;
	logic    ev_pressed;
	btn_id_e ev_btn;
	logic    pop;
	logic    empty;
	logic    rd_pressed;
	btn_id_e rd_btn;

	assign dipsw_reg = `DIPSW_DEFAULT; // Read by the game core

	ps2_key_capture u_capture (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.ps2_key    (ps2_key),
		.push       (push),
		.ev_pressed (ev_pressed),
		.ev_btn     (ev_btn)
	);

	key_event_fifo #(
		.ADDR_W (`IN_FIFO_AW)
	) u_fifo (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.push       (push),
		.wr_pressed (ev_pressed),
		.wr_btn     (ev_btn),
		.pop        (pop),
		.empty      (empty),
		.rd_pressed (rd_pressed),
		.rd_btn     (rd_btn),
		.overflow   (overflow)
	);

	cabinet_input_mapper u_mapper (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.empty      (empty),
		.rd_pressed (rd_pressed),
		.rd_btn     (rd_btn),
		.pop        (pop),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.rotate     (rotate),
		.in0_reg    (in0_reg),
		.in1_reg    (in1_reg)
	);

endmodule

//--- cabinet_input_mapper.sv
// Cabinet input mapper
// Applies queued button events at the game clock-enable rate, keeps the
// button states, ORs in both joysticks, handles rotated controls and
// forms the two active-low input registers read by the game CPU.

`timescale 1ns/10ps
`include "input_defs.svh"

module cabinet_input_mapper (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               empty,
	input  logic               rd_pressed,
	input  input_pkg::btn_id_e rd_btn,
	output logic               pop,
	input  logic [7:0]         joystick_0, // Bits 5 to 7 are extra fire buttons
	input  logic [7:0]         joystick_1,
	input  logic               rotate,
	output logic [7:0]         in0_reg,
	output logic [7:0]         in1_reg
);
	import input_pkg::*;

	logic [`CE_DIV_BITS-1:0] ce_div;
	mapper_state_e           state_q;
	mapper_state_e           state_d;
	logic [7:0]              btn_q; // Indexed by btn_id_e

	logic j_right, j_left, j_down, j_up, j_fire;
	logic s_up, s_down, s_left, s_right;
	logic m_up, m_down, m_left, m_right, m_fire;

	// ==================================================
	// Clock enable and event FSM
	// ==================================================
	always_comb begin
		state_d = state_q;
		case (state_q)
			mst_idle:  if (ce_div == '1) state_d = mst_apply;
			mst_apply: state_d = mst_idle; // Enable lasts one cycle
			default:   state_d = mst_idle;
		endcase
	end

	// One event per enable
	assign pop = (state_q == mst_apply) && !empty;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ce_div <= '0;
			state_q <= mst_idle;
			btn_q <= '0; // All released
		end else begin
			ce_div <= ce_div + 1'b1;
			state_q <= state_d;
			if (pop) btn_q[rd_btn] <= rd_pressed;
		end
	end

	// ==================================================
	// Joystick merge and rotation
	// ==================================================
	assign j_right = joystick_0[0] | joystick_1[0];
	assign j_left  = joystick_0[1] | joystick_1[1];
	assign j_down  = joystick_0[2] | joystick_1[2];
	assign j_up    = joystick_0[3] | joystick_1[3];
	assign j_fire  = joystick_0[4] | joystick_1[4];

	// Upright sources
	assign s_up    = btn_q[btn_up] | j_up;
	assign s_down  = btn_q[btn_down] | j_down;
	assign s_left  = btn_q[btn_left] | j_left;
	assign s_right = btn_q[btn_right] | j_right;

	// Rotate low turns the controls a quarter turn
	assign m_up    = rotate ? s_up : s_left;
	assign m_down  = rotate ? s_down : s_right;
	assign m_left  = rotate ? s_left : s_down;
	assign m_right = rotate ? s_right : s_up;
	assign m_fire  = btn_q[btn_fire] | j_fire;

	// Active-low CPU input ports
	assign in0_reg = ~{2'b00, btn_q[btn_coin], 1'b0, m_down, m_right, m_left, m_up};
	assign in1_reg = ~{1'b0, btn_q[btn_start2], btn_q[btn_start1], m_fire, 4'b0000};

endmodule

//--- input_defs.svh
// Control-input constants
// Sizes for the event FIFO and the game clock-enable divider,
// plus the dip-switch setting handed to the game core.

`ifndef INPUT_DEFS_SVH
`define INPUT_DEFS_SVH

// ==================================================
// Event FIFO
// ==================================================
`define IN_FIFO_AW 3 // 8 entries

// ==================================================
// Game clock enable
// ==================================================
// One enable every 2**CE_DIV_BITS system clocks
`define CE_DIV_BITS 2

// ==================================================
// Dip switches
// ==================================================
`define DIPSW_DEFAULT 8'b0111_0011

`endif

//--- input_pkg.sv
// Control-input package
// Shared types for the keyboard capture, event FIFO and cabinet mapper.
// Scan codes follow PS/2 set 2, button ids index the mapper's state vector.

package input_pkg;

	// ==================================================
	// Recognised keyboard scan codes
	// ==================================================
	typedef enum logic [7:0] {
		sc_start1 = 8'h05, // F1
		sc_start2 = 8'h06, // F2
		sc_fire   = 8'h29, // Space
		sc_left   = 8'h6B,
		sc_down   = 8'h72,
		sc_right  = 8'h74,
		sc_up     = 8'h75,
		sc_coin   = 8'h76  // ESC
	} scan_code_e;

	// ==================================================
	// Cabinet buttons
	// ==================================================
	// Value doubles as the bit index in the mapper
	typedef enum logic [2:0] {
		btn_up     = 3'd0,
		btn_down   = 3'd1,
		btn_left   = 3'd2,
		btn_right  = 3'd3,
		btn_coin   = 3'd4,
		btn_start1 = 3'd5,
		btn_start2 = 3'd6,
		btn_fire   = 3'd7
	} btn_id_e;

	// Mapper FSM
	typedef enum logic {
		mst_idle  = 1'b0, // Waiting for the next clock enable
		mst_apply = 1'b1  // Enable cycle, one event may be applied
	} mapper_state_e;

endpackage

//--- input_vectors.txt
# Columns: command, then arguments in hex (wait and burst in decimal)
# key|same code pressed, joy j0 j1, rot v, burst n, wait n, expect in0 in1 ovf, applied, reset
expect ff ff 0
key 75 1
key 29 1
wait 40
expect fe ef 0
key 75 0
key 76 1
key 05 1
key 06 1
wait 40
expect df 8f 0
key 1c 1
same 74 1
wait 40
expect df 8f 0
key 6b 1
joy 01 08
wait 40
expect d8 8f 0
rot 0
expect d2 8f 0
reset
burst 12
wait 40
applied
reset
expect ff ff 0

//--- key_event_fifo.sv
// Button event FIFO
// First-word-fall-through circular buffer between the keyboard capture
// and the cabinet mapper. A push into a full buffer is lost and raises
// a sticky overflow flag that only reset clears.

`timescale 1ns/10ps
`include "input_defs.svh"

module key_event_fifo #(
	parameter int ADDR_W = `IN_FIFO_AW
) (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               push,
	input  logic               wr_pressed,
	input  input_pkg::btn_id_e wr_btn,
	input  logic               pop,
	output logic               empty,
	output logic               rd_pressed,
	output input_pkg::btn_id_e rd_btn,
	output logic               overflow
);
	import input_pkg::*;

	localparam int DEPTH = 1 << ADDR_W;

	logic        mem_pressed [DEPTH];
	btn_id_e     mem_btn     [DEPTH];
	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;
	logic [ADDR_W:0]   count;
	logic        full;
	logic        wr_en;
	logic        rd_en;

	assign full  = count == DEPTH[ADDR_W:0];
	assign empty = count == '0;
	assign wr_en = push && !full;
	assign rd_en = pop && !empty;

	// Head entry, valid while not empty
	assign rd_pressed = mem_pressed[rd_ptr];
	assign rd_btn     = mem_btn[rd_ptr];

	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			mem_pressed[wr_ptr] <= wr_pressed;
			mem_btn[wr_ptr] <= wr_btn;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (wr_en) wr_ptr <= wr_ptr + 1'b1;
			if (rd_en) rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Idle or push with pop
			endcase
			if (push && full) overflow <= 1'b1; // Keyboard cannot be stalled
		end
	end

endmodule

//--- ps2_key_capture.sv
// Keyboard event capture
// Watches the toggle bit of the host key word and, for each new event
// carrying a recognised scan code, emits one push strobe with the
// translated button id and its pressed state.

`timescale 1ns/10ps

module ps2_key_capture (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic [10:0]        ps2_key, // {toggle, pressed, code}
	output logic               push,
	output logic               ev_pressed,
	output input_pkg::btn_id_e ev_btn
);
	import input_pkg::*;

	logic    toggle_q; // Toggle seen at the previous edge
	logic    new_event;
	logic    hit;
	btn_id_e btn_d;

	assign new_event = ps2_key[10] != toggle_q;

	// Scan code to button
	always_comb begin
		hit = 1'b1;
		btn_d = btn_up;
		case (scan_code_e'(ps2_key[7:0]))
			sc_up:     btn_d = btn_up;
			sc_down:   btn_d = btn_down;
			sc_left:   btn_d = btn_left;
			sc_right:  btn_d = btn_right;
			sc_coin:   btn_d = btn_coin;
			sc_start1: btn_d = btn_start1;
			sc_start2: btn_d = btn_start2;
			sc_fire:   btn_d = btn_fire;
			default:   hit = 1'b0; // Key not used by the game
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			toggle_q <= ps2_key[10]; // No phantom event on reset release
			push <= 1'b0;
		end else begin
			toggle_q <= ps2_key[10];
			push <= new_event && hit;
		end
	end

	// Payload
	always_ff @(posedge clk_sys) begin
		ev_pressed <= ps2_key[9];
		ev_btn <= btn_d;
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the arcade control-input testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_arcade_input \
	-f tb.f \
	-o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "test passed" sim.log; then
	echo "Simulation result: PASS"
else
	echo "Simulation result: FAIL"
	exit 1
fi

//--- tb.f
+incdir+.
input_pkg.sv
ps2_key_capture.sv
key_event_fifo.sv
cabinet_input_mapper.sv
arcade_input_top.sv
arcade_input_properties.sv
tb_arcade_input.sv

//--- tb_arcade_input.sv
// Control-input testbench
// Runs the command script in input_vectors.txt against the top level,
// checks the CPU input registers and the overflow flag after each step
// and stops the run at a cycle limit taken from the script's waits.

`timescale 1ns/10ps
`include "input_defs.svh"

module tb_arcade_input;
	import input_pkg::*;

	logic        clk_sys = 1'b0;
	logic        rst_n;
	logic [10:0] ps2_key;
	logic [7:0]  joystick_0;
	logic [7:0]  joystick_1;
	logic        rotate;
	logic [7:0]  in0_reg;
	logic [7:0]  in1_reg;
	logic [7:0]  dipsw_reg;
	logic        overflow;

	string       lines[$];
	int          cycle_cnt = 0;
	int          cycle_limit;
	int          n_tests;
	int          n_fail;
	logic [31:0] lfsr;
	logic [15:0] min_mask; // Active bits the first FIFO load of a burst must show
	logic [15:0] max_mask; // Active bits any burst event may show

	arcade_input_top dut (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.ps2_key    (ps2_key),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.rotate     (rotate),
		.in0_reg    (in0_reg),
		.in1_reg    (in1_reg),
		.dipsw_reg  (dipsw_reg),
		.overflow   (overflow)
	);

	bind arcade_input_top arcade_input_properties u_props (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.ps2_key  (ps2_key),
		.push     (push),
		.empty    (empty),
		.overflow (overflow),
		.state    (u_mapper.state_q)
	);

	initial begin
		forever #50 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("Run stopped at the cycle limit of %0d", cycle_limit);
			$display("test failed");
			$finish;
		end
	end

	// ==================================================
	// Helpers
	// ==================================================
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	// One LFSR step per index bit
	function automatic logic [2:0] draw_index();
		logic [2:0] idx;
		for (int i = 0; i < 3; i++) begin
			lfsr = lfsr_step(lfsr);
			idx[i] = lfsr[0];
		end
		return idx;
	endfunction

	// Scan code and its active bits in {in1_reg, in0_reg}, rotate high
	function automatic logic [23:0] key_entry(input logic [2:0] idx);
		case (idx)
			3'd0:    return {8'h75, 16'h0001}; // Up
			3'd1:    return {8'h72, 16'h0008}; // Down
			3'd2:    return {8'h6B, 16'h0002}; // Left
			3'd3:    return {8'h74, 16'h0004}; // Right
			3'd4:    return {8'h76, 16'h0020}; // Coin
			3'd5:    return {8'h05, 16'h2000};
			3'd6:    return {8'h06, 16'h4000};
			default: return {8'h29, 16'h1000}; // Fire
		endcase
	endfunction

	task automatic end_check(input string what, input logic ok);
		n_tests++;
		if (!ok) n_fail++;
		$display("Check %0d, %s: %s", n_tests, what, ok ? "ok" : "FAILED");
	endtask

	// New event flips the toggle, keep_toggle repeats the old one
	task automatic send_key(input logic [7:0] code, input logic pressed, input logic keep_toggle);
		@(negedge clk_sys);
		ps2_key = {ps2_key[10] ^ !keep_toggle, pressed, 1'b0, code};
	endtask

	task automatic apply_reset();
		@(negedge clk_sys);
		rst_n = 1'b0;
		joystick_0 = '0;
		joystick_1 = '0;
		rotate = 1'b1; // Upright controls
		repeat (3) @(negedge clk_sys);
		rst_n = 1'b1;
	endtask

	task automatic check_regs(input logic [7:0] exp0, input logic [7:0] exp1, input logic exp_ovf);
		logic ok;
		ok = 1'b1;
		@(negedge clk_sys);
		if (in0_reg !== exp0) begin
			$display("[ERROR] %0t ns: in0_reg is %h, expected %h", $time, in0_reg, exp0);
			ok = 1'b0;
		end
		if (in1_reg !== exp1) begin
			$display("[ERROR] %0t ns: in1_reg is %h, expected %h", $time, in1_reg, exp1);
			ok = 1'b0;
		end
		if (overflow !== exp_ovf) begin
			$display("[ERROR] %0t ns: overflow is %b, expected %b", $time, overflow, exp_ovf);
			ok = 1'b0;
		end
		end_check("registers", ok);
	endtask

	task automatic run_burst(input int count);
		logic [23:0] entry;
		min_mask = '0;
		max_mask = '0;
		for (int i = 0; i < count; i++) begin
			entry = key_entry(draw_index());
			if (i < (1 << `IN_FIFO_AW)) min_mask |= entry[15:0];
			max_mask |= entry[15:0];
			send_key(entry[23:16], 1'b1, 1'b0);
		end
	endtask

	// Later burst events may be lost, the first FIFO load never is
	task automatic check_burst();
		logic [15:0] active;
		logic        ok;
		ok = 1'b1;
		@(negedge clk_sys);
		active = ~{in1_reg, in0_reg};
		if ((active & min_mask) != min_mask || (active & ~max_mask) != '0) begin
			$display("[ERROR] %0t ns: active bits %h, need %h within %h", $time, active,
				min_mask, max_mask);
			ok = 1'b0;
		end
		if (overflow !== 1'b1) begin
			$display("[ERROR] %0t ns: overflow is %b after the burst, expected 1", $time, overflow);
			ok = 1'b0;
		end
		end_check("burst", ok);
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		int    fd;
		int    a;
		int    b;
		int    c;
		string line;
		string cmd;
		rst_n = 1'b0;
		ps2_key = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		rotate = 1'b1;
		n_tests = 0;
		n_fail = 0;
		lfsr = 32'h1ac3_d8e0;
		cycle_limit = 200;
		fd = $fopen("input_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open input_vectors.txt");
			n_fail++;
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
					lines.push_back(line);
					if ($sscanf(line, "wait %d", a) == 1) cycle_limit += a;
				end
			end
			$fclose(fd);
		end

		repeat (3) @(negedge clk_sys);
		rst_n = 1'b1;
		// Factory dip-switch setting
		if (dipsw_reg !== 8'b0111_0011) begin
			$display("[ERROR] %0t ns: dipsw_reg is %h, expected 73", $time, dipsw_reg);
			end_check("dip switches", 1'b0);
		end else begin
			end_check("dip switches", 1'b1);
		end

		foreach (lines[i]) begin
			void'($sscanf(lines[i], "%s %h %h %h", cmd, a, b, c));
			case (cmd)
				"key":  send_key(a[7:0], b[0], 1'b0);
				"same": send_key(a[7:0], b[0], 1'b1); // Toggle unchanged
				"joy": begin
					@(negedge clk_sys);
					joystick_0 = a[7:0];
					joystick_1 = b[7:0];
				end
				"rot": begin
					@(negedge clk_sys);
					rotate = a[0];
				end
				"burst": begin
					void'($sscanf(lines[i], "%s %d", cmd, a));
					run_burst(a);
				end
				"wait": begin
					void'($sscanf(lines[i], "%s %d", cmd, a));
					repeat (a) @(negedge clk_sys);
				end
				"expect":  check_regs(a[7:0], b[7:0], c[0]);
				"applied": check_burst();
				"reset":   apply_reset();
				default: begin
					$display("Unknown command in input_vectors.txt: %s", cmd);
					n_fail++;
				end
			endcase
		end

		$display("%0d checks run, %0d failed", n_tests, n_fail);
		if (n_fail == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule
